/* src/replay_gate_pkg.sv */
/* shared widths, bounds and types for the record/replay gate
   import into every module that needs the trace entry or counter sizes */

package replay_gate_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // width of one recorded data beat
  localparam int DATA_WIDTH = 16;
  // number of event channels in a trace entry
  localparam int LOGE_CNT = 2;

  // worst-case gap between runtime and replay counts on one channel
  // skid entries plus the output register plus some slack
  localparam int SKID_DEPTH = 2;
  localparam int OUT_REG_DEPTH = 1;
  localparam int OTF_MARGIN = 3;
  localparam int ON_THE_FLY_CNT = SKID_DEPTH + OUT_REG_DEPTH + OTF_MARGIN;

  // both counts stay on the same half circle, so the msb works as a sign
  localparam int PKT_CNT_WIDTH = $clog2(2 * ON_THE_FLY_CNT);

  // channel whose ready the ready replayer regenerates
  localparam int READY_LOGE_IDX = 1;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // one event mark per channel
  typedef logic [LOGE_CNT-1:0] loge_vec_t;

  // one trace entry, optional beat plus event marks
  typedef struct packed {
    logic                  logb_valid;
    logic [DATA_WIDTH-1:0] logb_data;
    loge_vec_t             loge;
  } replay_entry_t;

  // skid buffer occupancy
  typedef enum logic [1:0] {EMPTY, BUSY, FULL} skid_state_e;

endpackage

/* src/hb_diff_counter.sv */
/* per-channel runtime-minus-replay difference counters for happen-before
   checks; exposes the sign before and after the replay subtraction */

`timescale 1ns/1ps

module hb_diff_counter (
  input  logic                       i_clk,
  input  logic                       i_rstn,
  input  replay_gate_pkg::loge_vec_t i_rt_loge,
  input  replay_gate_pkg::loge_vec_t i_sub_loge,
  output replay_gate_pkg::loge_vec_t o_behind_pre,
  output replay_gate_pkg::loge_vec_t o_behind_post
);
  import replay_gate_pkg::*;

  // running difference, runtime count minus replay count
  logic [PKT_CNT_WIDTH-1:0] diff_q    [LOGE_CNT];
  // after this cycle's runtime pulse only
  logic [PKT_CNT_WIDTH-1:0] diff_pre  [LOGE_CNT];
  // after runtime pulse and replay mark
  logic [PKT_CNT_WIDTH-1:0] diff_post [LOGE_CNT];

  for (genvar i = 0; i < LOGE_CNT; i++) begin : g_chan
    assign diff_pre[i]  = diff_q[i] + PKT_CNT_WIDTH'(i_rt_loge[i]);
    assign diff_post[i] = diff_pre[i] - PKT_CNT_WIDTH'(i_sub_loge[i]);

    // msb set means the runtime side is still behind the replay side
    assign o_behind_pre[i]  = diff_pre[i][PKT_CNT_WIDTH-1];
    assign o_behind_post[i] = diff_post[i][PKT_CNT_WIDTH-1];

    // wraps freely, the gap never exceeds half the counter range
    always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
        diff_q[i] <= '0;
      end else begin
        diff_q[i] <= diff_post[i];
      end
    end
  end

endmodule

/* src/replay_skid_buffer.sv */
/* two-entry skid buffer for trace entries, head register plus spare register
   entries without a data beat retire from the head after one cycle */

`timescale 1ns/1ps

module replay_skid_buffer (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                i_push_valid,
  input  replay_gate_pkg::replay_entry_t      i_push_entry,
  output logic                                o_push_ready,
  input  logic                                i_pop_logb,
  output logic [replay_gate_pkg::DATA_WIDTH-1:0] o_head_data,
  output logic                                o_head_logb_next,
  output logic                                o_nonempty_next,
  output replay_gate_pkg::loge_vec_t          o_load_loge
);
  import replay_gate_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // occupancy FSM
  //   EMPTY -load-> BUSY -fill-> FULL
  //   FULL -flush-> BUSY -unload-> EMPTY, BUSY -flow-> BUSY
  ////////////////////////////////////////////////////////////////////////////

  skid_state_e   state;
  skid_state_e   state_next;

  // head and spare storage
  logic          head_logb;
  replay_entry_t spare;

  logic          push;
  logic          pop;
  logic          retire_nobeat;
  logic          load_en;
  replay_entry_t load_entry;

  assign push = i_push_valid && o_push_ready;
  // head without a beat only carries marks, it leaves on the next edge
  assign retire_nobeat = (state != EMPTY) && !head_logb;
  assign pop = i_pop_logb || retire_nobeat;

  always_comb begin
    state_next = state;
    case (state)
      EMPTY: begin
        // load
        if (push) begin
          state_next = BUSY;
        end
      end
      BUSY: begin
        // fill or unload, flow and idle stay put
        if (push && !pop) begin
          state_next = FULL;
        end else if (!push && pop) begin
          state_next = EMPTY;
        end
      end
      FULL: begin
        // flush, push cannot happen here since ready is low
        if (pop) begin
          state_next = BUSY;
        end
      end
      default: state_next = EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= EMPTY;
    end else begin
      state <= state_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  // new head comes from the spare on flush, else straight from the input
  assign load_entry = (state == FULL) ? spare : i_push_entry;
  assign load_en = (state_next == BUSY) && ((state == FULL) || push);

  // marks of the entry entering the head, counted against runtime now
  assign o_load_loge = load_en ? load_entry.loge : '0;
  assign o_head_logb_next = load_en ? load_entry.logb_valid : head_logb;
  assign o_nonempty_next = (state_next != EMPTY);

  // spare only takes an entry on fill
  always_ff @(posedge clk) begin
    if ((state == BUSY) && (state_next == FULL)) begin
      spare <= i_push_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      o_head_data <= load_entry.logb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      head_logb <= 1'b0;
    end else begin
      head_logb <= o_head_logb_next;
    end
  end

  // registered ready, low only while full next cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_push_ready <= 1'b0;
    end else begin
      o_push_ready <= (state_next != FULL);
    end
  end

endmodule

/* src/valid_replayer.sv */
/* replays recorded data beats on a valid/ready output, each beat held back
   until every channel's runtime event count has reached its replay count */

`timescale 1ns/1ps

module valid_replayer (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  logic                                   i_trace_valid,
  input  replay_gate_pkg::replay_entry_t         i_trace_entry,
  output logic                                   o_trace_ready,
  input  replay_gate_pkg::loge_vec_t             i_rt_loge,
  output logic                                   o_out_valid,
  input  logic                                   i_out_ready,
  output logic [replay_gate_pkg::DATA_WIDTH-1:0] o_out_data
);
  import replay_gate_pkg::*;

  loge_vec_t load_loge;
  loge_vec_t behind_post;
  logic      head_logb_next;
  logic      nonempty_next;
  logic      out_xfer;

  assign out_xfer = o_out_valid && i_out_ready;

  replay_skid_buffer u_skid (
    .clk              (clk),
    .rstn             (rstn),
    .i_push_valid     (i_trace_valid),
    .i_push_entry     (i_trace_entry),
    .o_push_ready     (o_trace_ready),
    .i_pop_logb       (out_xfer),
    .o_head_data      (o_out_data),
    .o_head_logb_next (head_logb_next),
    .o_nonempty_next  (nonempty_next),
    .o_load_loge      (load_loge)
  );

  // marks count as soon as their entry reaches the head
  hb_diff_counter u_hb (
    .i_clk         (clk),
    .i_rstn        (rstn),
    .i_rt_loge     (i_rt_loge),
    .i_sub_loge    (load_loge),
    .o_behind_pre  (),
    .o_behind_post (behind_post)
  );

  ////////////////////////////////////////////////////////////////////////////
  // gate
  ////////////////////////////////////////////////////////////////////////////

  // registered from next-state terms so the gate stays off the output path
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_out_valid <= 1'b0;
    end else begin
      o_out_valid <= nonempty_next && head_logb_next && !(|behind_post);
    end
  end

endmodule

/* src/ready_replayer.sv */
/* takes loge masks from the ready-path trace under happen-before and
   regenerates a registered ready for channel READY_LOGE_IDX */

`timescale 1ns/1ps

module ready_replayer (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       i_rdy_valid,
  input  replay_gate_pkg::loge_vec_t i_rdy_loge,
  output logic                       o_rdy_taken,
  input  replay_gate_pkg::loge_vec_t i_rt_loge,
  output logic                       o_ready
);
  import replay_gate_pkg::*;

  loge_vec_t behind_pre;
  loge_vec_t behind_post;
  loge_vec_t sub_loge;
  logic      take;

  // accept a mask once runtime has caught up everywhere, this cycle included
  assign o_rdy_taken = !(|behind_pre);
  assign take = i_rdy_valid && o_rdy_taken;
  assign sub_loge = take ? i_rdy_loge : '0;

  hb_diff_counter u_hb (
    .i_clk         (clk),
    .i_rstn        (rstn),
    .i_rt_loge     (i_rt_loge),
    .i_sub_loge    (sub_loge),
    .o_behind_pre  (behind_pre),
    .o_behind_post (behind_post)
  );

  // ready stays up while the selected channel still owes runtime events
  // visible one cycle after the mask is taken
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_ready <= 1'b0;
    end else begin
      o_ready <= behind_post[READY_LOGE_IDX];
    end
  end

endmodule

/* src/replay_gate_top.sv */
/* record/replay gate top level, data-beat replayer and ready replayer side by
   side, both watching the same runtime event marks */

`timescale 1ns/1ps

module replay_gate_top (
  input  logic                                   clk,
  input  logic                                   rstn,
  // trace entries in
  input  logic                                   i_trace_valid,
  input  replay_gate_pkg::replay_entry_t         i_trace_entry,
  output logic                                   o_trace_ready,
  // runtime event pulses, no back-pressure
  input  replay_gate_pkg::loge_vec_t             i_rt_loge,
  // replayed beats out
  output logic                                   o_out_valid,
  input  logic                                   i_out_ready,
  output logic [replay_gate_pkg::DATA_WIDTH-1:0] o_out_data,
  // ready-path masks in
  input  logic                                   i_rdy_valid,
  input  replay_gate_pkg::loge_vec_t             i_rdy_loge,
  output logic                                   o_rdy_taken,
  // regenerated ready
  output logic                                   o_ready
);

  valid_replayer u_valid (
    .clk           (clk),
    .rstn          (rstn),
    .i_trace_valid (i_trace_valid),
    .i_trace_entry (i_trace_entry),
    .o_trace_ready (o_trace_ready),
    .i_rt_loge     (i_rt_loge),
    .o_out_valid   (o_out_valid),
    .i_out_ready   (i_out_ready),
    .o_out_data    (o_out_data)
  );

  // same runtime marks, separate replay count
  ready_replayer u_ready (
    .clk         (clk),
    .rstn        (rstn),
    .i_rdy_valid (i_rdy_valid),
    .i_rdy_loge  (i_rdy_loge),
    .o_rdy_taken (o_rdy_taken),
    .i_rt_loge   (i_rt_loge),
    .o_ready     (o_ready)
  );

endmodule

/* bench/replay_gate_asserts.sv */
/* concurrent handshake checks for the record/replay gate, bound into the
   top level so every simulation of the top picks them up */

`timescale 1ns/1ps

module replay_gate_asserts (
  input logic                                   clk,
  input logic                                   rstn,
  input logic                                   i_trace_valid,
  input replay_gate_pkg::replay_entry_t         i_trace_entry,
  input logic                                   o_trace_ready,
  input logic                                   o_out_valid,
  input logic                                   i_out_ready,
  input logic [replay_gate_pkg::DATA_WIDTH-1:0] o_out_data,
  input logic                                   i_rdy_valid,
  input replay_gate_pkg::loge_vec_t             i_rdy_loge,
  input logic                                   o_rdy_taken,
  input logic                                   o_ready
);

  // each valid holds with stable payload until its transfer
  a_trace_hold: assert property (@(posedge clk) disable iff (!rstn)
    (i_trace_valid && !o_trace_ready) |=> (i_trace_valid && $stable(i_trace_entry)))
    else $error("trace entry dropped or changed before acceptance");
  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data)))
    else $error("output beat dropped or changed before transfer");
  a_rdy_hold: assert property (@(posedge clk) disable iff (!rstn)
    (i_rdy_valid && !o_rdy_taken) |=> (i_rdy_valid && $stable(i_rdy_loge)))
    else $error("ready-path mask dropped or changed before intake");

  // quiet in reset and on the first cycle out of it
  a_reset_out: assert property (@(posedge clk)
    !rstn |=> (!o_out_valid && !o_trace_ready && !o_ready))
    else $error("output high during reset");
  a_reset_in: assert property (@(posedge clk) !rstn |-> (!i_trace_valid && !i_rdy_valid))
    else $error("input valid high during reset");
  a_first_cycle: assert property (@(posedge clk) $rose(rstn) |=> (!o_out_valid && !o_ready))
    else $error("output high on first cycle after reset");

endmodule

bind replay_gate_top replay_gate_asserts u_asserts (.*);

/* bench/replay_gate_tb.sv */
/* testbench for the record/replay gate, replays bench/replay_input.txt
   against a count model of both happen-before paths */

`timescale 1ns/1ps

module replay_gate_tb;
  import replay_gate_pkg::*;

  logic                  clk;
  logic                  rstn;
  logic                  i_trace_valid;
  replay_entry_t         i_trace_entry;
  logic                  o_trace_ready;
  loge_vec_t             i_rt_loge;
  logic                  o_out_valid;
  logic                  i_out_ready;
  logic [DATA_WIDTH-1:0] o_out_data;
  logic                  i_rdy_valid;
  loge_vec_t             i_rdy_loge;
  logic                  o_rdy_taken;
  logic                  o_ready;

  // file contents, cum_marks holds marks summed through each trace entry
  replay_entry_t         trace_mem [$];
  loge_vec_t             rdy_mem [$];
  logic [DATA_WIDTH-1:0] beat_exp [$];
  int                    beat_pos [$];
  int                    cum_marks [64][LOGE_CNT];
  int                    file_lines;

  // count model, all counts taken at rising edges
  int          rt_cnt [LOGE_CNT];
  int          trace_cnt [LOGE_CNT];
  int          rdy_cnt [LOGE_CNT];
  int          trace_idx;
  int          rdy_idx;
  int          beats_out;
  logic        exp_ready;
  logic        trace_xfer;
  logic        rdy_xfer;
  logic [31:0] lfsr;
  int          errs [0:6];
  int          checks;
  int          cycles;
  int          total;

  replay_gate_top dut (.*);

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  function automatic logic run_done();
    return (beats_out == beat_exp.size()) && (trace_idx == trace_mem.size())
           && (rdy_idx == rdy_mem.size());
  endfunction

  task automatic load_trace();
    int                    fd;
    int                    code;
    string                 line;
    logic                  v;
    loge_vec_t             m;
    logic [DATA_WIDTH-1:0] d;
    logic [DATA_WIDTH-1:0] e;
    replay_entry_t         ent;
    int                    run [LOGE_CNT];
    fd = $fopen("bench/replay_input.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/replay_input.txt");
      errs[0]++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ((line.len() > 0) && (line[0] == "T")) begin
        code = $sscanf(line, "T %b %b %h %h", v, m, d, e);
        if (code != 4) begin
          $display("malformed trace line in data file: %s", line);
          errs[0]++;
        end
        for (int c = 0; c < LOGE_CNT; c++) begin
          run[c] += m[c];
          cum_marks[trace_mem.size()][c] = run[c];
        end
        // expected column only matters for entries with a beat
        if (v) begin
          beat_exp.push_back(e);
          beat_pos.push_back(trace_mem.size());
        end
        ent.logb_valid = v;
        ent.logb_data = d;
        ent.loge = m;
        trace_mem.push_back(ent);
        file_lines++;
      end else if ((line.len() > 0) && (line[0] == "R")) begin
        code = $sscanf(line, "R %b", m);
        if (code != 1) begin
          $display("malformed ready-path line in data file: %s", line);
          errs[0]++;
        end
        rdy_mem.push_back(m);
        file_lines++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // per-edge checks and model update, values seen just before the edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic sample_edge();
    logic exp_taken;
    int   done_pos;
    exp_taken = 1'b1;
    checks += 3;
    // registered ready follows the counts of the previous edge
    if (o_ready !== exp_ready) begin
      $display("[ERROR] %0t o_ready got %b expected %b", $time, o_ready, exp_ready);
      errs[6]++;
    end
    // intake open only once runtime, this cycle included, has caught up
    for (int c = 0; c < LOGE_CNT; c++) begin
      if (rt_cnt[c] + i_rt_loge[c] < rdy_cnt[c]) begin
        exp_taken = 1'b0;
      end
    end
    if (o_rdy_taken !== exp_taken) begin
      $display("[ERROR] %0t o_rdy_taken got %b expected %b", $time, o_rdy_taken, exp_taken);
      errs[5]++;
    end
    if (o_out_valid === 1'b1) begin
      if (beats_out >= beat_exp.size()) begin
        $display("o_out_valid raised at %0t after the last beat of the trace", $time);
        errs[2]++;
      end else begin
        for (int c = 0; c < LOGE_CNT; c++) begin
          if (rt_cnt[c] < cum_marks[beat_pos[beats_out]][c]) begin
            $display("o_out_valid high at %0t with channel %0d runtime %0d below replay %0d",
                     $time, c, rt_cnt[c], cum_marks[beat_pos[beats_out]][c]);
            errs[3]++;
          end
        end
      end
    end
    // full means head and spare both hold entries past the last beat out
    done_pos = (beats_out == 0) ? 0 : beat_pos[beats_out-1] + 1;
    if ((o_trace_ready !== 1'b1) && (trace_idx - done_pos < 2)) begin
      $display("o_trace_ready low at %0t with fewer than two entries waiting", $time);
      errs[4]++;
    end
    if (o_out_valid && i_out_ready && (beats_out < beat_exp.size())) begin
      checks++;
      if (o_out_data !== beat_exp[beats_out]) begin
        $display("[ERROR] %0t o_out_data got %h expected %h", $time, o_out_data,
                 beat_exp[beats_out]);
        errs[2]++;
      end
      beats_out++;
    end
    trace_xfer = i_trace_valid && o_trace_ready;
    if (trace_xfer) begin
      for (int c = 0; c < LOGE_CNT; c++) begin
        trace_cnt[c] += trace_mem[trace_idx].loge[c];
      end
      trace_idx++;
    end
    rdy_xfer = i_rdy_valid && o_rdy_taken;
    if (rdy_xfer) begin
      for (int c = 0; c < LOGE_CNT; c++) begin
        rdy_cnt[c] += rdy_mem[rdy_idx][c];
      end
      rdy_idx++;
    end
    for (int c = 0; c < LOGE_CNT; c++) begin
      rt_cnt[c] += i_rt_loge[c];
    end
    exp_ready = (rt_cnt[READY_LOGE_IDX] < rdy_cnt[READY_LOGE_IDX]);
  endtask

  // falling-edge stimulus, valids hold until their transfer
  task automatic drive_inputs();
    logic b;
    int   lim;
    draw_bit(b);
    i_out_ready = b;
    if (!i_trace_valid || trace_xfer) begin
      i_trace_valid = 1'b0;
      if (trace_idx < trace_mem.size()) begin
        draw_bit(b);
        i_trace_valid = b;
        i_trace_entry = trace_mem[trace_idx];
      end
    end
    if (!i_rdy_valid || rdy_xfer) begin
      i_rdy_valid = 1'b0;
      if (rdy_idx < rdy_mem.size()) begin
        draw_bit(b);
        i_rdy_valid = b;
        i_rdy_loge = rdy_mem[rdy_idx];
      end
    end
    // runtime may lead the slower replay count by at most the on-the-fly bound
    for (int c = 0; c < LOGE_CNT; c++) begin
      draw_bit(b);
      lim = (trace_cnt[c] < rdy_cnt[c]) ? trace_cnt[c] : rdy_cnt[c];
      i_rt_loge[c] = b && (rt_cnt[c] + 1 - lim <= ON_THE_FLY_CNT);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    i_trace_valid = 1'b0;
    i_trace_entry = '0;
    i_rt_loge = '0;
    i_out_ready = 1'b0;
    i_rdy_valid = 1'b0;
    i_rdy_loge = '0;
    lfsr = 32'hcbc7_8104;
    exp_ready = 1'b0;
    trace_xfer = 1'b0;
    rdy_xfer = 1'b0;
    load_trace();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(posedge clk);
    checks += 2;
    if ({o_trace_ready, o_out_valid, o_ready} !== 3'b000) begin
      $display("[ERROR] %0t {o_trace_ready,o_out_valid,o_ready} got %b expected 000",
               $time, {o_trace_ready, o_out_valid, o_ready});
      errs[1]++;
    end
    @(negedge clk);
    if (o_trace_ready !== 1'b1) begin
      $display("[ERROR] %0t o_trace_ready got %b expected 1", $time, o_trace_ready);
      errs[1]++;
    end
    $display("test 1 reset values: %0d errors", errs[1]);
    drive_inputs();
    // limit scales with the length of the data file
    while (!run_done() && (cycles < 40 * file_lines)) begin
      @(posedge clk);
      sample_edge();
      @(negedge clk);
      drive_inputs();
      cycles++;
    end
    if (!run_done()) begin
      $display("timeout after %0d cycles with %0d of %0d beats replayed", cycles,
               beats_out, beat_exp.size());
      errs[0]++;
    end
    // idle tail, no further beat may appear
    repeat (4) begin
      @(posedge clk);
      sample_edge();
      @(negedge clk);
      drive_inputs();
    end
    checks++;
    if (beats_out != beat_exp.size()) begin
      $display("[ERROR] %0t beats out got %0d expected %0d", $time, beats_out,
               beat_exp.size());
      errs[4]++;
    end
    $display("test 2 beat order and data: %0d errors", errs[2]);
    $display("test 3 valid gated by runtime counts: %0d errors", errs[3]);
    $display("test 4 back-pressure and beat total: %0d errors", errs[4]);
    $display("test 5 ready-path intake: %0d errors", errs[5]);
    $display("test 6 regenerated ready: %0d errors", errs[6]);
    total = 0;
    for (int i = 0; i <= 6; i++) begin
      total += errs[i];
    end
    $display("%0d cycles, %0d checks, %0d errors", cycles, checks, total);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* bench/replay_input.txt */
# T logb_valid loge(bin, ch1 ch0) data(hex) expected_beat(hex)
# R loge(bin) ready-path mask, taken in file order
T 1 01 a001 a001
T 1 10 a002 a002
T 0 11 0000 0000
T 1 00 a004 a004
T 1 11 a005 a005
T 0 01 0000 0000
T 0 10 0000 0000
T 1 01 a008 a008
T 1 10 a009 a009
T 1 11 a00a a00a
T 0 00 0000 0000
T 1 01 a00c a00c
R 01
R 10
R 11
R 11
R 10
R 01

/* replay_gate.f */
src/replay_gate_pkg.sv
src/hb_diff_counter.sv
src/replay_skid_buffer.sv
src/valid_replayer.sv
src/ready_replayer.sv
src/replay_gate_top.sv
bench/replay_gate_asserts.sv
bench/replay_gate_tb.sv

/* Bender.yml */
package:
  name: replay_gate

sources:
  - src/replay_gate_pkg.sv
  - src/hb_diff_counter.sv
  - src/replay_skid_buffer.sv
  - src/valid_replayer.sv
  - src/ready_replayer.sv
  - src/replay_gate_top.sv
  - target: test
    files:
      - bench/replay_gate_asserts.sv
      - bench/replay_gate_tb.sv
